/* design/host_map_pkg.sv */
// Host bus and register map
`default_nettype none

package host_map_pkg;

  // ----------------------------------------------------------------------
  // Wishbone host bus widths
  // ----------------------------------------------------------------------
  localparam int HOST_ADDR_W = 16;
  localparam int HOST_DATA_W = 32;
  localparam int HOST_SEL_W  = 4;

  // Bit 15 of the byte address picks the memory window
  localparam int MEM_WIN_BIT = 15;
  localparam int REG_OFF_W   = MEM_WIN_BIT - 2;

  // Word offsets inside the register window
  localparam logic [REG_OFF_W-1:0] REG_ID0   = 13'd0;
  localparam logic [REG_OFF_W-1:0] REG_ID1   = 13'd1;
  localparam logic [REG_OFF_W-1:0] REG_VLED  = 13'd2;
  localparam logic [REG_OFF_W-1:0] REG_VDIP  = 13'd3;
  localparam logic [REG_OFF_W-1:0] REG_CYCLE = 13'd4;

  localparam logic [HOST_DATA_W-1:0] CL_ID0 = 32'hF000_1D0F;
  localparam logic [HOST_DATA_W-1:0] CL_ID1 = 32'h1D51_FEDD;

  localparam int               VLED_W     = 16;
  localparam logic [VLED_W-1:0] VLED_VALUE = 16'hBEEF;

  typedef struct packed {
    logic                   cyc;
    logic                   stb;
    logic                   we;
    logic [HOST_ADDR_W-1:0] adr;
    logic [HOST_DATA_W-1:0] dat;
    logic [HOST_SEL_W-1:0]  sel;
  } host_req_t;

  typedef struct packed {
    logic                   ack;
    logic [HOST_DATA_W-1:0] dat;
  } host_rsp_t;

  typedef struct packed {
    logic [VLED_W-1:0]      vled;
    logic [VLED_W-1:0]      vdip;
    logic [HOST_DATA_W-1:0] cycle;
  } status_t;

endpackage

`default_nettype wire

/* design/mc_link_pkg.sv */
// Manycore link packet format
`default_nettype none

package mc_link_pkg;

  // ----------------------------------------------------------------------
  // Link field widths
  // ----------------------------------------------------------------------
  localparam int MC_X_W        = 4;
  localparam int MC_Y_W        = 4;
  localparam int MC_EPA_W      = 8;
  localparam int MC_DATA_W     = 32;
  localparam int MC_MASK_W     = MC_DATA_W / 8;
  localparam int MC_LOAD_ID_W  = 5;
  localparam int MC_LOAD_PAD_W = MC_DATA_W - MC_LOAD_ID_W;
  localparam int MC_MEM_WORDS  = 1 << MC_EPA_W;

  // Node coordinates on the link
  localparam logic [MC_X_W-1:0] HOST_X = 4'd0;
  localparam logic [MC_Y_W-1:0] HOST_Y = 4'd0;
  localparam logic [MC_X_W-1:0] MEM_X  = 4'd1;
  localparam logic [MC_Y_W-1:0] MEM_Y  = 4'd0;

  typedef enum logic [1:0] {
    MC_OP_LOAD  = 2'd0,
    MC_OP_STORE = 2'd1,
    MC_OP_RESP  = 2'd2
  } mc_op_e;

  typedef struct packed {
    logic [MC_LOAD_PAD_W-1:0] pad;
    logic [MC_LOAD_ID_W-1:0]  load_id;
  } mc_load_info_t;

  // Stores carry a data word, loads carry their ID
  typedef union packed {
    logic [MC_DATA_W-1:0] data;
    mc_load_info_t        load_info;
  } mc_payload_u;

  typedef struct packed {
    mc_op_e                op;
    logic [MC_MASK_W-1:0]  mask;
    logic [MC_EPA_W-1:0]   epa;
    mc_payload_u           payload;
    logic [MC_X_W-1:0]     src_x;
    logic [MC_Y_W-1:0]     src_y;
    logic [MC_X_W-1:0]     dst_x;
    logic [MC_Y_W-1:0]     dst_y;
  } mc_packet_t;

endpackage

`default_nettype wire

/* design/host_status_regs.sv */
// Shell status registers
`default_nettype none

module host_status_regs (
  input  wire                                      clk_main_a0,
  input  wire                                      rst_main_n_sync,
  input  wire  logic [host_map_pkg::VLED_W-1:0]    sh_cl_status_vdip_i,
  output host_map_pkg::status_t                    status_o
);

  logic [host_map_pkg::VLED_W-1:0] vdip_q1;
  logic [host_map_pkg::VLED_W-1:0] vdip_q2;
  host_map_pkg::status_t           status_q;

  // ----------------------------------------------------------------------
  // DIP synchronizer, LED value and cycle counter
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vdip_q1  <= '0;
      vdip_q2  <= '0;
      status_q <= '0;
    end else begin
      // Two flops for the asynchronous switches
      vdip_q1        <= sh_cl_status_vdip_i;
      vdip_q2        <= vdip_q1;
      status_q.vdip  <= vdip_q2;
      // LEDs show a fixed pattern once out of reset
      status_q.vled  <= host_map_pkg::VLED_VALUE;
      // Free running, wraps silently
      status_q.cycle <= status_q.cycle + 1'b1;
    end
  end

  assign status_o = status_q;

endmodule

`default_nettype wire

/* design/host_mc_bridge.sv */
// Wishbone to manycore link bridge
`default_nettype none

module host_mc_bridge (
  input  wire                              clk_main_a0,
  input  wire                              rst_main_n_sync,
  input  wire  host_map_pkg::host_req_t    host_req_i,
  output host_map_pkg::host_rsp_t          host_rsp_o,
  input  wire  host_map_pkg::status_t      status_i,
  output logic                             req_v_o,
  output mc_link_pkg::mc_packet_t          req_pkt_o,
  input  wire                              rsp_v_i,
  input  wire  mc_link_pkg::mc_packet_t    rsp_pkt_i
);

  logic                                   ack_q;
  logic [host_map_pkg::HOST_DATA_W-1:0]   dat_q;
  logic                                   busy_q;
  logic                                   req_v_q;
  mc_link_pkg::mc_packet_t                req_pkt_q;
  mc_link_pkg::mc_packet_t                req_pkt_d;
  logic [mc_link_pkg::MC_LOAD_ID_W-1:0]   load_id_q;
  logic                                   new_acc;
  logic                                   mem_win;
  logic [host_map_pkg::REG_OFF_W-1:0]     reg_off;
  logic [host_map_pkg::HOST_DATA_W-1:0]   reg_rdata;
  logic                                   rsp_match;

  // A new access is taken only with nothing in flight and no ack pending
  assign new_acc = host_req_i.cyc && host_req_i.stb && !ack_q && !busy_q;
  assign mem_win = host_req_i.adr[host_map_pkg::MEM_WIN_BIT];
  assign reg_off = host_req_i.adr[host_map_pkg::MEM_WIN_BIT-1:2];

  // ----------------------------------------------------------------------
  // Register window read mux
  // ----------------------------------------------------------------------
  always_comb begin
    case (reg_off)
      host_map_pkg::REG_ID0:   reg_rdata = host_map_pkg::CL_ID0;
      host_map_pkg::REG_ID1:   reg_rdata = host_map_pkg::CL_ID1;
      host_map_pkg::REG_VLED:  reg_rdata = {16'h0000, status_i.vled};
      host_map_pkg::REG_VDIP:  reg_rdata = {16'h0000, status_i.vdip};
      host_map_pkg::REG_CYCLE: reg_rdata = status_i.cycle;
      default:                 reg_rdata = '0;
    endcase
  end

  // ----------------------------------------------------------------------
  // Request packet from the current Wishbone access
  // ----------------------------------------------------------------------
  always_comb begin
    req_pkt_d.op    = host_req_i.we ? mc_link_pkg::MC_OP_STORE : mc_link_pkg::MC_OP_LOAD;
    req_pkt_d.mask  = host_req_i.sel;
    req_pkt_d.epa   = host_req_i.adr[mc_link_pkg::MC_EPA_W+1:2];
    req_pkt_d.src_x = mc_link_pkg::HOST_X;
    req_pkt_d.src_y = mc_link_pkg::HOST_Y;
    req_pkt_d.dst_x = mc_link_pkg::MEM_X;
    req_pkt_d.dst_y = mc_link_pkg::MEM_Y;
    if (host_req_i.we) begin
      req_pkt_d.payload.data = host_req_i.dat;
    end else begin
      req_pkt_d.payload.load_info.pad     = '0;
      req_pkt_d.payload.load_info.load_id = load_id_q;
    end
  end

  // Load responses echo the load ID in the low epa bits
  assign rsp_match = rsp_v_i && busy_q
                  && (rsp_pkt_i.op == mc_link_pkg::MC_OP_RESP)
                  && (rsp_pkt_i.dst_x == mc_link_pkg::HOST_X)
                  && (rsp_pkt_i.dst_y == mc_link_pkg::HOST_Y)
                  && ((req_pkt_q.op == mc_link_pkg::MC_OP_STORE)
                      || (rsp_pkt_i.epa[mc_link_pkg::MC_LOAD_ID_W-1:0]
                          == req_pkt_q.payload.load_info.load_id));

  // ----------------------------------------------------------------------
  // Control state
  // ----------------------------------------------------------------------
  // Only one access is ever outstanding, so the endpoint needs no ready
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      ack_q     <= 1'b0;
      busy_q    <= 1'b0;
      req_v_q   <= 1'b0;
      load_id_q <= '0;
    end else begin
      ack_q   <= (new_acc && !mem_win) || rsp_match;
      req_v_q <= new_acc && mem_win;
      if (new_acc && mem_win) begin
        busy_q <= 1'b1;
      end else if (rsp_match) begin
        busy_q <= 1'b0;
      end
      if (new_acc && mem_win && !host_req_i.we) begin
        load_id_q <= load_id_q + 1'b1;
      end
    end
  end

  // Payload registers
  always_ff @(posedge clk_main_a0) begin
    if (new_acc && mem_win) begin
      req_pkt_q <= req_pkt_d;
    end
    if (new_acc && !mem_win) begin
      dat_q <= reg_rdata;
    end else if (rsp_match) begin
      dat_q <= rsp_pkt_i.payload.data;
    end
  end

  assign host_rsp_o.ack = ack_q;
  assign host_rsp_o.dat = dat_q;
  assign req_v_o        = req_v_q;
  assign req_pkt_o      = req_pkt_q;

endmodule

`default_nettype wire

/* design/mc_mem_endpoint.sv */
// Manycore memory endpoint
`default_nettype none

module mc_mem_endpoint (
  input  wire                              clk_main_a0,
  input  wire                              rst_main_n_sync,
  input  wire                              req_v_i,
  input  wire  mc_link_pkg::mc_packet_t    req_pkt_i,
  output logic                             rsp_v_o,
  output mc_link_pkg::mc_packet_t          rsp_pkt_o
);

  logic [mc_link_pkg::MC_DATA_W-1:0] mem_q [mc_link_pkg::MC_MEM_WORDS];
  logic                              req_hit;
  logic                              rsp_v_q;
  mc_link_pkg::mc_packet_t           rsp_pkt_q;

  // Only packets addressed to this node are served
  assign req_hit = req_v_i
                && (req_pkt_i.dst_x == mc_link_pkg::MEM_X)
                && (req_pkt_i.dst_y == mc_link_pkg::MEM_Y);

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rsp_v_q <= 1'b0;
    end else begin
      rsp_v_q <= req_hit;
    end
  end

  // ----------------------------------------------------------------------
  // Byte-masked store and response build
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (req_hit && (req_pkt_i.op == mc_link_pkg::MC_OP_STORE)) begin
      for (int b = 0; b < mc_link_pkg::MC_MASK_W; b++) begin
        if (req_pkt_i.mask[b]) begin
          mem_q[req_pkt_i.epa][8*b +: 8] <= req_pkt_i.payload.data[8*b +: 8];
        end
      end
    end
    if (req_hit) begin
      rsp_pkt_q.op    <= mc_link_pkg::MC_OP_RESP;
      rsp_pkt_q.mask  <= req_pkt_i.mask;
      rsp_pkt_q.src_x <= mc_link_pkg::MEM_X;
      rsp_pkt_q.src_y <= mc_link_pkg::MEM_Y;
      // Reply goes back to whoever asked
      rsp_pkt_q.dst_x <= req_pkt_i.src_x;
      rsp_pkt_q.dst_y <= req_pkt_i.src_y;
      if (req_pkt_i.op == mc_link_pkg::MC_OP_LOAD) begin
        rsp_pkt_q.epa          <= mc_link_pkg::MC_EPA_W'(req_pkt_i.payload.load_info.load_id);
        rsp_pkt_q.payload.data <= mem_q[req_pkt_i.epa];
      end else begin
        rsp_pkt_q.epa               <= '0;
        rsp_pkt_q.payload.load_info <= '0;
      end
    end
  end

  assign rsp_v_o   = rsp_v_q;
  assign rsp_pkt_o = rsp_pkt_q;

endmodule

`default_nettype wire

/* design/cl_manycore_top.sv */
// Manycore host shell top
`default_nettype none

module cl_manycore_top (
  input  wire                                      clk_main_a0,
  input  wire                                      rst_main_n_sync,
  input  wire  host_map_pkg::host_req_t            host_req_i,
  output host_map_pkg::host_rsp_t                  host_rsp_o,
  input  wire  logic [host_map_pkg::VLED_W-1:0]    sh_cl_status_vdip_i,
  output logic [host_map_pkg::VLED_W-1:0]          cl_sh_status_vled_o
);

  host_map_pkg::status_t   status;
  logic                    req_v;
  mc_link_pkg::mc_packet_t req_pkt;
  logic                    rsp_v;
  mc_link_pkg::mc_packet_t rsp_pkt;

  host_status_regs u_status (
    .clk_main_a0         (clk_main_a0),
    .rst_main_n_sync     (rst_main_n_sync),
    .sh_cl_status_vdip_i (sh_cl_status_vdip_i),
    .status_o            (status)
  );

  // ----------------------------------------------------------------------
  // Host side request/response path
  // ----------------------------------------------------------------------
  host_mc_bridge u_bridge (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .host_req_i      (host_req_i),
    .host_rsp_o      (host_rsp_o),
    .status_i        (status),
    .req_v_o         (req_v),
    .req_pkt_o       (req_pkt),
    .rsp_v_i         (rsp_v),
    .rsp_pkt_i       (rsp_pkt)
  );

  mc_mem_endpoint u_mem (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .req_v_i         (req_v),
    .req_pkt_i       (req_pkt),
    .rsp_v_o         (rsp_v),
    .rsp_pkt_o       (rsp_pkt)
  );

  assign cl_sh_status_vled_o = status.vled;

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
// Testbench clock and reset
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD     = 10,
  parameter int RST_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // Reset low for the first few rising edges, released away from them
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

/* testbench/tb_cl_manycore.sv */
// Manycore host shell testbench
`default_nettype none

module tb_cl_manycore;

  localparam int N_DIP      = 8;
  localparam int N_FILL     = mc_link_pkg::MC_MEM_WORDS;
  localparam int N_RAND     = 200;
  localparam int N_UNMAPPED = 8;
  localparam int N_OPS      = 3 + N_DIP + N_FILL + N_RAND + 2 + 6 + 2 * N_UNMAPPED;
  localparam int WD_CYCLES  = N_OPS * 20 + 200;
  localparam int ACK_LIMIT  = 16;

  // Expected ID words and LED pattern
  localparam logic [31:0] EXP_ID0  = 32'hF000_1D0F;
  localparam logic [31:0] EXP_ID1  = 32'h1D51_FEDD;
  localparam logic [31:0] EXP_VLED = 32'h0000_BEEF;

  logic                            clk;
  logic                            rst_n;
  host_map_pkg::host_req_t         host_req;
  host_map_pkg::host_rsp_t         host_rsp;
  logic [host_map_pkg::VLED_W-1:0] vdip;
  logic [host_map_pkg::VLED_W-1:0] vled;

  logic [31:0] rng_state;
  logic [31:0] mem_model [mc_link_pkg::MC_MEM_WORDS];
  int          checks_run;
  int          errors;
  int          test_start_errors;

  tb_clock_gen #(.PERIOD(10), .RST_CYCLES(4)) u_clk (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  cl_manycore_top u_dut (
    .clk_main_a0         (clk),
    .rst_main_n_sync     (rst_n),
    .host_req_i          (host_req),
    .host_rsp_o          (host_rsp),
    .sh_cl_status_vdip_i (vdip),
    .cl_sh_status_vled_o (vled)
  );

  // ----------------------------------------------------------------------
  // Random numbers and reference model helpers
  // ----------------------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic draw_random(output logic [31:0] r);
    rng_state = xorshift32(rng_state);
    r = rng_state;
  endtask

  // Every byte depends on the full word address
  function automatic logic [31:0] fill_word(input logic [7:0] a);
    return {a, ~a, a ^ 8'h5A, a + 8'h3C};
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  sel);
    logic [31:0] w;
    w = old_w;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        w[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return w;
  endfunction

  function automatic logic [15:0] mem_addr(input logic [7:0] epa, input logic [4:0] hi);
    return {1'b1, hi, epa, 2'b00};
  endfunction

  function automatic logic [15:0] reg_addr(input logic [12:0] off);
    return {1'b0, off, 2'b00};
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks_run++;
    assert (got === exp) else begin
      $display("[FAIL] %s expected %h got %h", name, exp, got);
      errors++;
    end
  endtask

  task automatic start_test();
    test_start_errors = errors;
  endtask

  task automatic finish_test(input int num, input string name);
    $display("Test %0d %s: %0d errors", num, name, errors - test_start_errors);
  endtask

  // ----------------------------------------------------------------------
  // Wishbone classic transfer, called on a falling edge
  // ----------------------------------------------------------------------
  task automatic bus_access(input logic we, input logic [15:0] adr, input logic [31:0] wdat,
                            input logic [3:0] sel, output logic [31:0] rdat);
    int   waited;
    logic acked;
    waited       = 0;
    acked        = 1'b0;
    rdat         = '0;
    host_req.cyc = 1'b1;
    host_req.stb = 1'b1;
    host_req.we  = we;
    host_req.adr = adr;
    host_req.dat = wdat;
    host_req.sel = sel;
    while (!acked && waited < ACK_LIMIT) begin
      @(negedge clk);
      waited++;
      if (host_rsp.ack) begin
        acked = 1'b1;
        rdat  = host_rsp.dat;
      end
    end
    host_req.cyc = 1'b0;
    host_req.stb = 1'b0;
    host_req.we  = 1'b0;
    checks_run++;
    assert (acked) else begin
      $display("No ack for the access to address %h within %0d cycles", adr, ACK_LIMIT);
      errors++;
    end
    // Ack must drop after a single cycle
    @(negedge clk);
    checks_run++;
    assert (!host_rsp.ack) else begin
      $display("Ack stayed high for more than one cycle at address %h", adr);
      errors++;
    end
  endtask

  task automatic reg_read(input logic [12:0] off, output logic [31:0] rdat);
    bus_access(1'b0, reg_addr(off), 32'h0, 4'hF, rdat);
  endtask

  task automatic reg_write(input logic [12:0] off, input logic [31:0] wdat);
    logic [31:0] unused;
    bus_access(1'b1, reg_addr(off), wdat, 4'hF, unused);
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial begin
    logic [31:0] rd;
    logic [31:0] r;
    logic [31:0] wd;
    logic [31:0] c1;
    logic [31:0] c2;
    logic [7:0]  epa;
    logic [12:0] off;
    int          i;
    host_req   = '0;
    vdip       = '0;
    rng_state  = 32'd36;
    checks_run = 0;
    errors     = 0;
    @(posedge rst_n);
    @(negedge clk);

    start_test();
    reg_read(host_map_pkg::REG_ID0, rd);
    check_value("host_rsp_o.dat REG_ID0", rd, EXP_ID0);
    reg_read(host_map_pkg::REG_ID1, rd);
    check_value("host_rsp_o.dat REG_ID1", rd, EXP_ID1);
    finish_test(1, "ID words");

    start_test();
    check_value("cl_sh_status_vled_o", {16'h0000, vled}, EXP_VLED);
    reg_read(host_map_pkg::REG_VLED, rd);
    check_value("host_rsp_o.dat REG_VLED", rd, EXP_VLED);
    finish_test(2, "LED after reset");

    // Synchronizer needs three edges before the value is visible
    start_test();
    for (i = 0; i < N_DIP; i++) begin
      draw_random(r);
      vdip = r[15:0];
      repeat (3) @(negedge clk);
      reg_read(host_map_pkg::REG_VDIP, rd);
      check_value("host_rsp_o.dat REG_VDIP", rd, {16'h0000, r[15:0]});
    end
    finish_test(3, "DIP readback");

    start_test();
    for (i = 0; i < N_FILL; i++) begin
      mem_model[i] = fill_word(8'(i));
      bus_access(1'b1, mem_addr(8'(i), 5'd0), mem_model[i], 4'hF, rd);
    end
    for (i = 0; i < N_RAND; i++) begin
      draw_random(r);
      draw_random(wd);
      epa = r[7:0];
      if (r[8]) begin
        bus_access(1'b1, mem_addr(epa, r[20:16]), wd, r[12:9], rd);
        mem_model[epa] = merge_bytes(mem_model[epa], wd, r[12:9]);
      end else begin
        bus_access(1'b0, mem_addr(epa, r[20:16]), wd, 4'hF, rd);
        check_value("host_rsp_o.dat memory load", rd, mem_model[epa]);
      end
    end
    finish_test(4, "random memory traffic");

    start_test();
    reg_read(host_map_pkg::REG_CYCLE, c1);
    repeat (10) @(negedge clk);
    reg_read(host_map_pkg::REG_CYCLE, c2);
    checks_run++;
    assert (c2 > c1) else begin
      $display("[FAIL] host_rsp_o.dat REG_CYCLE expected above %h got %h", c1, c2);
      errors++;
    end
    finish_test(5, "cycle counter");

    start_test();
    draw_random(r);
    reg_write(host_map_pkg::REG_ID0, r);
    draw_random(r);
    reg_write(host_map_pkg::REG_ID1, r);
    draw_random(r);
    reg_write(host_map_pkg::REG_VLED, r);
    for (i = 0; i < N_UNMAPPED; i++) begin
      draw_random(r);
      draw_random(wd);
      off = 13'(32'd5 + (r % 32'd8187));
      reg_write(off, wd);
      reg_read(off, rd);
      check_value("host_rsp_o.dat unmapped offset", rd, 32'h0);
    end
    reg_read(host_map_pkg::REG_ID0, rd);
    check_value("host_rsp_o.dat REG_ID0", rd, EXP_ID0);
    reg_read(host_map_pkg::REG_ID1, rd);
    check_value("host_rsp_o.dat REG_ID1", rd, EXP_ID1);
    reg_read(host_map_pkg::REG_VLED, rd);
    check_value("host_rsp_o.dat REG_VLED", rd, EXP_VLED);
    check_value("cl_sh_status_vled_o", {16'h0000, vled}, EXP_VLED);
    finish_test(6, "register writes and unmapped reads");

    $display("Checks run: %0d, failures: %0d", checks_run, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // Watchdog sized from the number of bus operations
  initial begin
    repeat (WD_CYCLES) @(posedge clk);
    $display("Timeout: the run did not finish within %0d cycles", WD_CYCLES);
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
design/host_map_pkg.sv
design/mc_link_pkg.sv
design/host_status_regs.sv
design/host_mc_bridge.sv
design/mc_mem_endpoint.sv
design/cl_manycore_top.sv
testbench/tb_clock_gen.sv
testbench/tb_cl_manycore.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, result taken from sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_cl_manycore \
  -f tb.f -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { echo "Build or simulation run failed"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -qF "** FAIL **" sim.log && { echo "Simulation reported errors"; exit 1; }
grep -qF "** PASS **" sim.log || { echo "No result found in sim.log"; exit 1; }
echo "Simulation finished without errors"
